/* rtl/spi_target_pkg.sv */
package spi_target_pkg;

   // ------------------------------
   // Data widths
   // ------------------------------

   // One SPI byte or one bus data byte
   // Sent and received MSB first on the wire
   typedef logic [7:0] spi_byte_t;

   // FIFO pointer, one bit wider than the FIFO address
   // Top bit tells a full FIFO from an empty one
   // Same type for the binary and the Gray form
   typedef logic [4:0] fifo_ptr_t;

   // ------------------------------
   // Constants
   // ------------------------------

   // Entries in each async FIFO
   localparam int FIFO_DEPTH = 16;

   // First byte on MISO in every transaction
   localparam spi_byte_t HEADER_BYTE = 8'hA7;

   // ------------------------------
   // Bus sequencer FSM
   // ------------------------------

   typedef enum logic [1:0] {
      // Waiting for a pending read or a received byte
      BUS_IDLE,
      // Read strobe out, waiting for ack
      BUS_READ,
      // Turnaround, strobe low for one cycle
      BUS_WAIT,
      // Write strobe out, waiting for ack
      BUS_SEND
   } bus_state_e;

endpackage

/* rtl/spi_shift_unit.sv */
`timescale 1ns/1ps

module spi_shift_unit (
   input  logic                      sck_i,
   input  logic                      SSEL,
   input  logic                      mosi_i,
   input  spi_target_pkg::spi_byte_t tx_data,
   input  logic                      tx_empty,
   input  logic                      rx_full,
   output logic                      miso_o,
   output logic                      rx_push,
   output spi_target_pkg::spi_byte_t rx_byte,
   output logic                      tx_pull,
   output logic                      spi_req_tgl,
   output logic                      overflow_o,
   output logic                      underrun_o
);

   // Seven bits held, the eighth comes straight from MOSI
   logic [6:0] rx_reg;
   logic [2:0] rx_count;
   // Bits still to be shifted out after the one on MISO
   logic [6:0] tx_reg;
   logic [2:0] tx_count;

   // ------------------------------
   // Receive, rising SCK edge
   // ------------------------------

   // Deserializer, MSB first
   always_ff @(posedge sck_i) begin
      rx_reg <= {rx_reg[5:0], mosi_i};
   end

   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         rx_count <= '0;
      end else begin
         rx_count <= rx_count + 3'd1;
      end
   end

   // Byte complete on the edge that samples bit 0
   assign rx_push = (rx_count == 3'd7);
   assign rx_byte = {rx_reg, mosi_i};

   // One toggle per completed byte asks for the next prefetch
   // Sticky overflow when a byte arrives at a full RX FIFO
   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         spi_req_tgl <= 1'b0;
         overflow_o  <= 1'b0;
      end else if (rx_push) begin
         spi_req_tgl <= ~spi_req_tgl;
         if (rx_full) begin
            overflow_o <= 1'b1;
         end
      end
   end

   // ------------------------------
   // Transmit, falling SCK edge
   // ------------------------------

   always_ff @(negedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         tx_count <= '0;
      end else begin
         tx_count <= tx_count + 3'd1;
      end
   end

   // Last bit of the byte sent, load the next one from the TX FIFO
   assign tx_pull = (tx_count == 3'd7);

   // Header sits in the serializer while deselected
   // Mode 0 needs bit 7 on MISO before the first rising edge
   always_ff @(negedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         miso_o <= spi_target_pkg::HEADER_BYTE[7];
         tx_reg <= spi_target_pkg::HEADER_BYTE[6:0];
      end else if (tx_pull) begin
         miso_o <= tx_data[7];
         tx_reg <= tx_data[6:0];
      end else begin
         miso_o <= tx_reg[6];
         tx_reg <= {tx_reg[5:0], 1'b0};
      end
   end

   // Sticky underrun, prefetched byte not there in time
   always_ff @(negedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         underrun_o <= 1'b0;
      end else if (tx_pull && tx_empty) begin
         underrun_o <= 1'b1;
      end
   end

endmodule

/* rtl/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo (
   input  logic                      SSEL,
   input  logic                      wr_clk_i,
   input  logic                      wr_en_i,
   input  spi_target_pkg::spi_byte_t wr_data_i,
   input  logic                      rd_clk_i,
   input  logic                      rd_en_i,
   output spi_target_pkg::spi_byte_t rd_data_o,
   output logic                      empty_o,
   output logic                      full_o
);

   spi_target_pkg::spi_byte_t mem [spi_target_pkg::FIFO_DEPTH];

   // Write domain pointers and the synchronized read pointer
   spi_target_pkg::fifo_ptr_t wr_bin, wr_bin_nxt, wr_gray;
   spi_target_pkg::fifo_ptr_t rd_gray_m, rd_gray_s;
   // Read domain pointers and the synchronized write pointer
   spi_target_pkg::fifo_ptr_t rd_bin, rd_bin_nxt, rd_gray;
   spi_target_pkg::fifo_ptr_t wr_gray_m, wr_gray_s;
   logic wr_ok, rd_ok;

   function automatic spi_target_pkg::fifo_ptr_t bin2gray(
      input spi_target_pkg::fifo_ptr_t bin
   );
      return bin ^ (bin >> 1);
   endfunction

   // ------------------------------
   // Write side
   // ------------------------------

   // Pushes into a full FIFO are dropped
   assign wr_ok      = wr_en_i && !full_o;
   assign wr_bin_nxt = wr_bin + 1'b1;

   always_ff @(posedge wr_clk_i) begin
      if (wr_ok) begin
         mem[wr_bin % spi_target_pkg::FIFO_DEPTH] <= wr_data_i;
      end
   end

   always_ff @(posedge wr_clk_i or posedge SSEL) begin
      if (SSEL) begin
         wr_bin    <= '0;
         wr_gray   <= '0;
         rd_gray_m <= '0;
         rd_gray_s <= '0;
      end else begin
         if (wr_ok) begin
            wr_bin  <= wr_bin_nxt;
            wr_gray <= bin2gray(wr_bin_nxt);
         end
         // Two-flop sync of the read pointer
         rd_gray_m <= rd_gray;
         rd_gray_s <= rd_gray_m;
      end
   end

   // Full when the Gray pointers differ in their two top bits only
   assign full_o = ((wr_gray ^ rd_gray_s) ==
                    spi_target_pkg::fifo_ptr_t'(spi_target_pkg::FIFO_DEPTH * 3 / 2));

   // ------------------------------
   // Read side
   // ------------------------------

   // Head of the FIFO is always on the output
   assign rd_ok      = rd_en_i && !empty_o;
   assign rd_bin_nxt = rd_bin + 1'b1;
   assign rd_data_o  = mem[rd_bin % spi_target_pkg::FIFO_DEPTH];

   always_ff @(posedge rd_clk_i or posedge SSEL) begin
      if (SSEL) begin
         rd_bin    <= '0;
         rd_gray   <= '0;
         wr_gray_m <= '0;
         wr_gray_s <= '0;
      end else begin
         if (rd_ok) begin
            rd_bin  <= rd_bin_nxt;
            rd_gray <= bin2gray(rd_bin_nxt);
         end
         wr_gray_m <= wr_gray;
         wr_gray_s <= wr_gray_m;
      end
   end

   assign empty_o = (rd_gray == wr_gray_s);

endmodule

/* rtl/bus_sequencer.sv */
`timescale 1ns/1ps

module bus_sequencer (
   input  logic                      clk_i,
   input  logic                      SSEL,
   input  logic                      spi_req_tgl,
   input  spi_target_pkg::spi_byte_t rx_byte_i,
   input  logic                      rx_empty,
   input  logic                      ack_i,
   input  spi_target_pkg::spi_byte_t dat_i,
   output logic                      rx_pull,
   output logic                      tx_push,
   output spi_target_pkg::spi_byte_t tx_byte_o,
   output logic                      cyc_o,
   output logic                      stb_o,
   output logic                      we_o,
   output spi_target_pkg::spi_byte_t dat_o
);

   spi_target_pkg::bus_state_e bus_state;
   logic sel_meta, sel_sync;
   logic tgl_meta, tgl_sync, tgl_prev;
   logic tgl_change;
   logic req_pend;
   logic read_start;

   // ------------------------------
   // Clock domain crossing
   // ------------------------------

   // Select is active low, so a high SSEL holds everything here cleared
   // cyc_o rises two or three clocks after select, falls at once on deselect
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         sel_meta <= 1'b0;
         sel_sync <= 1'b0;
      end else begin
         sel_meta <= 1'b1;
         sel_sync <= sel_meta;
      end
   end

   assign cyc_o = sel_sync;

   // Request toggle, two sync flops and one for edge detect
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         tgl_meta <= 1'b0;
         tgl_sync <= 1'b0;
         tgl_prev <= 1'b0;
      end else begin
         tgl_meta <= spi_req_tgl;
         tgl_sync <= tgl_meta;
         tgl_prev <= tgl_sync;
      end
   end

   assign tgl_change = tgl_sync ^ tgl_prev;

   // Pending read level
   // One read is owed at every select, for the byte after the header
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         req_pend <= 1'b1;
      end else if (tgl_change) begin
         req_pend <= 1'b1;
      end else if (read_start) begin
         req_pend <= 1'b0;
      end
   end

   // ------------------------------
   // Bus FSM
   // ------------------------------

   // Reads go first, the SPI side needs them before the next byte boundary
   assign read_start = cyc_o && req_pend && (bus_state == spi_target_pkg::BUS_IDLE);
   assign rx_pull    = cyc_o && !req_pend && !rx_empty &&
                       (bus_state == spi_target_pkg::BUS_IDLE);

   // Read data goes to the TX FIFO in the ack cycle
   assign tx_push   = ack_i && (bus_state == spi_target_pkg::BUS_READ);
   assign tx_byte_o = dat_i;

   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         bus_state <= spi_target_pkg::BUS_IDLE;
         stb_o     <= 1'b0;
         we_o      <= 1'b0;
      end else begin
         case (bus_state)
            spi_target_pkg::BUS_IDLE: begin
               if (read_start) begin
                  bus_state <= spi_target_pkg::BUS_READ;
                  stb_o     <= 1'b1;
                  we_o      <= 1'b0;
               end else if (rx_pull) begin
                  bus_state <= spi_target_pkg::BUS_SEND;
                  stb_o     <= 1'b1;
                  we_o      <= 1'b1;
               end
            end
            // Strobe held steady until ack
            spi_target_pkg::BUS_READ, spi_target_pkg::BUS_SEND: begin
               if (ack_i) begin
                  bus_state <= spi_target_pkg::BUS_WAIT;
                  stb_o     <= 1'b0;
                  we_o      <= 1'b0;
               end
            end
            default: begin
               bus_state <= spi_target_pkg::BUS_IDLE;
            end
         endcase
      end
   end

   // Write data, loaded as the byte leaves the RX FIFO
   always_ff @(posedge clk_i) begin
      if (rx_pull) begin
         dat_o <= rx_byte_i;
      end
   end

endmodule

/* rtl/spi_target.sv */
`timescale 1ns/1ps

module spi_target (
   // SPI side
   input  logic                      sck_i,
   input  logic                      SSEL,
   input  logic                      mosi_i,
   output logic                      miso_o,
   // Bus side
   input  logic                      clk_i,
   output logic                      cyc_o,
   output logic                      stb_o,
   output logic                      we_o,
   input  logic                      ack_i,
   input  spi_target_pkg::spi_byte_t dat_i,
   output spi_target_pkg::spi_byte_t dat_o,
   // Diagnostics
   output logic                      overflow_o,
   output logic                      underrun_o
);

   // Receive path, SCK to clk_i
   logic                      rx_push, rx_pull, rx_empty, rx_full;
   spi_target_pkg::spi_byte_t rx_byte, rx_data;
   // Transmit path, clk_i to SCK
   logic                      tx_push, tx_pull, tx_empty;
   spi_target_pkg::spi_byte_t tx_byte, tx_data;
   logic                      spi_req_tgl;

   // ------------------------------
   // SCK domain
   // ------------------------------

   spi_shift_unit shift_i (
      .sck_i       (sck_i),
      .SSEL        (SSEL),
      .mosi_i      (mosi_i),
      .tx_data     (tx_data),
      .tx_empty    (tx_empty),
      .rx_full     (rx_full),
      .miso_o      (miso_o),
      .rx_push     (rx_push),
      .rx_byte     (rx_byte),
      .tx_pull     (tx_pull),
      .spi_req_tgl (spi_req_tgl),
      .overflow_o  (overflow_o),
      .underrun_o  (underrun_o)
   );

   // ------------------------------
   // Crossings
   // ------------------------------

   // Write side on rising SCK, with the deserializer
   async_fifo rx_fifo_i (
      .SSEL      (SSEL),
      .wr_clk_i  (sck_i),
      .wr_en_i   (rx_push),
      .wr_data_i (rx_byte),
      .rd_clk_i  (clk_i),
      .rd_en_i   (rx_pull),
      .rd_data_o (rx_data),
      .empty_o   (rx_empty),
      .full_o    (rx_full)
   );

   // Read side on falling SCK, with the serializer
   // Sequencer pushes at most one byte per read, full is not needed
   async_fifo tx_fifo_i (
      .SSEL      (SSEL),
      .wr_clk_i  (clk_i),
      .wr_en_i   (tx_push),
      .wr_data_i (tx_byte),
      .rd_clk_i  (~sck_i),
      .rd_en_i   (tx_pull),
      .rd_data_o (tx_data),
      .empty_o   (tx_empty),
      .full_o    ()
   );

   // ------------------------------
   // clk_i domain
   // ------------------------------

   bus_sequencer seq_i (
      .clk_i       (clk_i),
      .SSEL        (SSEL),
      .spi_req_tgl (spi_req_tgl),
      .rx_byte_i   (rx_data),
      .rx_empty    (rx_empty),
      .ack_i       (ack_i),
      .dat_i       (dat_i),
      .rx_pull     (rx_pull),
      .tx_push     (tx_push),
      .tx_byte_o   (tx_byte),
      .cyc_o       (cyc_o),
      .stb_o       (stb_o),
      .we_o        (we_o),
      .dat_o       (dat_o)
   );

endmodule

/* verif/spi_target_assert.sv */
`timescale 1ns/1ps

module spi_target_assert (
   input logic                       clk_i,
   input logic                       SSEL,
   input logic                       cyc_i,
   input logic                       stb_i,
   input logic                       we_i,
   input logic                       ack_i,
   input spi_target_pkg::spi_byte_t  dat_i,
   input logic                       overflow_i,
   input logic                       underrun_i
);

   // Failed assertions so far
   int unsigned error_count = 0;

   // ------------------------------
   // Bus protocol
   // ------------------------------

   // Strobe, direction and write data steady until ack
   stb_hold_a: assert property (
      @(posedge clk_i) disable iff (SSEL)
      stb_i && !ack_i |=> stb_i && $stable(we_i) && $stable(dat_i)
   ) else begin
      $error("stb_o, we_o or dat_o changed before ack_i");
      error_count++;
   end

   // Strobe only inside the cycle frame
   stb_in_cyc_a: assert property (
      @(posedge clk_i) stb_i |-> cyc_i
   ) else begin
      $error("stb_o high while cyc_o low");
      error_count++;
   end

   // ------------------------------
   // Deselected
   // ------------------------------

   idle_in_reset_a: assert property (
      @(posedge clk_i) SSEL |-> !cyc_i && !stb_i && !overflow_i && !underrun_i
   ) else begin
      $error("bus or flags active while SSEL high");
      error_count++;
   end

endmodule

bind spi_target spi_target_assert assert_i (
   .clk_i       (clk_i),
   .SSEL        (SSEL),
   .cyc_i       (cyc_o),
   .stb_i       (stb_o),
   .we_i        (we_o),
   .ack_i       (ack_i),
   .dat_i       (dat_o),
   .overflow_i  (overflow_o),
   .underrun_i  (underrun_o)
);

/* verif/spi_target_tb.sv */
`timescale 1ns/1ps

module spi_target_tb;

   // SCK half period in clk_i cycles
   localparam int HALF_SCK  = 6;
   // Idle clocks after the last SCK edge, RX FIFO drains in this time
   localparam int DRAIN     = 40;
   localparam int NUM_TRANS = 4;

   logic                      clk_i;
   logic                      sck_i;
   logic                      SSEL;
   logic                      mosi_i;
   logic                      miso_o;
   logic                      cyc_o;
   logic                      stb_o;
   logic                      we_o;
   logic                      ack_i;
   spi_target_pkg::spi_byte_t dat_i;
   spi_target_pkg::spi_byte_t dat_o;
   logic                      overflow_o;
   logic                      underrun_o;

   // Responder withholds ack while set
   logic stall;

   // Logs of one transaction
   spi_target_pkg::spi_byte_t mosi_bytes[$];
   spi_target_pkg::spi_byte_t miso_got[$];
   spi_target_pkg::spi_byte_t write_log[$];
   spi_target_pkg::spi_byte_t read_log[$];

   spi_target spi_target_i (
      .sck_i      (sck_i),
      .SSEL       (SSEL),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .clk_i      (clk_i),
      .cyc_o      (cyc_o),
      .stb_o      (stb_o),
      .we_o       (we_o),
      .ack_i      (ack_i),
      .dat_i      (dat_i),
      .dat_o      (dat_o),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o)
   );

   always #4 clk_i = ~clk_i;

   // ------------------------------
   // Failure handling
   // ------------------------------

   task automatic stop_failed();
      $display("TEST FAIL");
      $fatal(1, "Stopping on first failure");
   endtask

   task automatic report_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
      stop_failed();
   endtask

   task automatic abort_run(input string reason);
      $display("%s, at %0t ns", reason, $time);
      stop_failed();
   endtask

   // Any bound protocol assertion failing ends the run
   always @(spi_target_i.assert_i.error_count) begin
      if (spi_target_i.assert_i.error_count != 0) begin
         abort_run("A bus protocol assertion failed");
      end
   end

   // ------------------------------
   // SPI master model
   // ------------------------------

   // Advance n rising edges, then the drive offset
   task automatic step_clocks(input int n);
      repeat (n) @(posedge clk_i);
      #1;
   endtask

   // Mode 0, MSB first, MISO captured at each rising SCK edge
   task automatic spi_transfer(input int n);
      spi_target_pkg::spi_byte_t rx;
      for (int i = 0; i < n; i++) begin
         for (int b = 7; b >= 0; b--) begin
            mosi_i = mosi_bytes[i][b];
            step_clocks(HALF_SCK);
            rx    = {rx[6:0], miso_o};
            sck_i = 1'b1;
            step_clocks(HALF_SCK);
            sck_i = 1'b0;
         end
         miso_got.push_back(rx);
      end
   endtask

   // ------------------------------
   // Bus responder
   // ------------------------------

   // Random ack delay of 0 to 3 cycles, ack high for one cycle
   initial begin : bus_responder
      int unsigned gap;
      spi_target_pkg::spi_byte_t rdata;
      ack_i = 1'b0;
      dat_i = '0;
      forever begin
         step_clocks(1);
         ack_i = 1'b0;
         if (stb_o && !stall) begin
            gap = $urandom_range(3, 0);
            repeat (gap) step_clocks(1);
            if (stb_o && !stall) begin
               if (we_o) begin
                  write_log.push_back(dat_o);
               end else begin
                  rdata = spi_byte_t_rand();
                  dat_i = rdata;
                  read_log.push_back(rdata);
               end
               ack_i = 1'b1;
            end
         end
      end
   end

   function automatic spi_target_pkg::spi_byte_t spi_byte_t_rand();
      return spi_target_pkg::spi_byte_t'($urandom);
   endfunction

   // ------------------------------
   // One transaction
   // ------------------------------

   task automatic run_transaction(input int n, input logic stalled);
      mosi_bytes.delete();
      miso_got.delete();
      write_log.delete();
      read_log.delete();
      for (int i = 0; i < n; i++) begin
         mosi_bytes.push_back(spi_byte_t_rand());
      end
      stall = stalled;
      SSEL  = 1'b0;
      step_clocks(HALF_SCK);
      spi_transfer(n);
      step_clocks(DRAIN);
      // Flags just before deselect
      if (stalled) begin
         assert (overflow_o === 1'b1) else report_value("overflow_o", 1, overflow_o);
         assert (underrun_o === 1'b1) else report_value("underrun_o", 1, underrun_o);
      end else begin
         assert (overflow_o === 1'b0) else report_value("overflow_o", 0, overflow_o);
         assert (underrun_o === 1'b0) else report_value("underrun_o", 0, underrun_o);
      end
      SSEL = 1'b1;
      step_clocks(1);
      stall = 1'b0;
      assert (overflow_o === 1'b0) else report_value("overflow_o", 0, overflow_o);
      assert (underrun_o === 1'b0) else report_value("underrun_o", 0, underrun_o);
      // Header always first on MISO
      assert (miso_got[0] === spi_target_pkg::HEADER_BYTE)
         else report_value("miso_o", spi_target_pkg::HEADER_BYTE, miso_got[0]);
      if (!stalled) begin
         // Every MOSI byte is one bus write, same order
         assert (write_log.size() == n) else report_value("write count", n, write_log.size());
         for (int i = 0; i < n; i++) begin
            assert (write_log[i] === mosi_bytes[i])
               else report_value("dat_o", mosi_bytes[i], write_log[i]);
         end
         // MISO byte k is the k-th read return
         assert (read_log.size() >= n - 1)
            else report_value("read count", n - 1, read_log.size());
         for (int k = 1; k < n; k++) begin
            assert (miso_got[k] === read_log[k - 1])
               else report_value("miso_o", read_log[k - 1], miso_got[k]);
         end
      end
      step_clocks(4);
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------

   initial begin
      void'($urandom(32'h1a99_e58b));
      clk_i  = 1'b0;
      sck_i  = 1'b0;
      mosi_i = 1'b0;
      stall  = 1'b0;
      SSEL   = 1'b0;
      // Rising select at 1 ns clears both domains
      #1;
      SSEL = 1'b1;
      repeat (4) @(posedge clk_i);
      #1;
      run_transaction(1, 1'b0);
      run_transaction(5, 1'b0);
      run_transaction(12, 1'b0);
      // Stalled bus, RX FIFO overflows and TX FIFO runs dry
      run_transaction(spi_target_pkg::FIFO_DEPTH + 4, 1'b1);
      if (spi_target_i.assert_i.error_count == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         abort_run("Protocol assertion failures were seen");
      end
   end

   initial begin : watchdog
      repeat (NUM_TRANS * 2000) @(posedge clk_i);
      abort_run("Watchdog expired before all transactions finished");
   end

endmodule

/* spi_target.f */
rtl/spi_target_pkg.sv
rtl/spi_shift_unit.sv
rtl/async_fifo.sv
rtl/bus_sequencer.sv
rtl/spi_target.sv
verif/spi_target_assert.sv
verif/spi_target_tb.sv
